/* flist.f */
source/memStagePkg.sv
source/storeFormat.sv
source/dataRam.sv
source/loadAlign.sv
source/memStage.sv
test/memStageTb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := memStageTb
RTL_TOP    := memStage
FLIST      := flist.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
PASS_MSG   := Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* test/memStageTb.sv */
// Memory stage testbench
// Random loads and stores checked against a byte-array memory model
`timescale 1ns/1ns

module memStageTb import memStagePkg::*; ();

  logic      clk;
  logic      reset;
  MemRequest request;
  MemResult  result;

  logic [7:0] model [0:4095];   // Byte image of the RAM
  MemResult   pending [$];      // Expected results, oldest first
  int         checkCount;
  int         errorCount;
  int         testCount;
  int         testChecks;
  int         testErrors;
  bit         timedOut;

  memStage uut (
    .clk     (clk),
    .reset   (reset),
    .request (request),
    .result  (result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string msg);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("error at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
    end
  endtask

  function automatic logic isAligned(input logic [1:0] size, input logic [31:0] addr);
    logic ok;
    case (size)
      ACCESS_WORD: ok = (addr[1:0] == 2'b00);
      ACCESS_HALF: ok = !addr[0];
      default:     ok = 1'b1;
    endcase
    return ok;
  endfunction

  // Little-endian read of the model, extended as the load asks
  function automatic logic [31:0] modelRead(input logic [31:0] addr, input LoadType lt);
    logic [11:0] a;
    logic [15:0] half;
    logic [7:0]  byteVal;
    logic [31:0] value;
    a       = addr[11:0];
    half    = {model[a + 12'd1], model[a]};
    byteVal = model[a];
    case (lt.size)
      ACCESS_WORD: value = {model[a + 12'd3], model[a + 12'd2], half};
      ACCESS_HALF: value = {{16{lt.signExt & half[15]}}, half};
      default:     value = {{24{lt.signExt & byteVal[7]}}, byteVal};
    endcase
    return value;
  endfunction

  function automatic void modelWrite(input logic [31:0] addr, input logic [31:0] data,
                                     input logic [1:0] size);
    logic [11:0] a;
    a = addr[11:0];
    model[a] = data[7:0];
    if (size != ACCESS_BYTE) begin
      model[a + 12'd1] = data[15:8];
    end
    if (size == ACCESS_WORD) begin
      model[a + 12'd2] = data[23:16];
      model[a + 12'd3] = data[31:24];
    end
  endfunction

  // Expected result, also commits aligned stores to the model
  function automatic MemResult predict(input MemRequest req);
    MemResult exp;
    logic     loadOk;
    logic     storeOk;
    loadOk  = isAligned(req.loadType.size, req.addr);
    storeOk = isAligned(req.storeType.size, req.addr);
    exp.valid  = req.loadType.readMem | req.storeType.dmWr;
    exp.except = req.except;
    exp.except.wrWrongAddressInMem = req.storeType.dmWr & !storeOk;
    exp.except.rdWrongAddressInMem = req.loadType.readMem & !loadOk;
    exp.loadData = 32'b0;
    if (req.loadType.readMem && loadOk) begin
      exp.loadData = modelRead(req.addr, req.loadType);
    end
    if (req.storeType.dmWr && storeOk) begin
      modelWrite(req.addr, req.storeData, req.storeType.size);
    end
    return exp;
  endfunction

  function automatic MemRequest makeStore(input logic [31:0] addr, input logic [31:0] data,
                                          input logic [1:0] size);
    MemRequest req;
    req                = '0;
    req.addr           = addr;
    req.storeData      = data;
    req.storeType.dmWr = 1'b1;
    req.storeType.size = size;
    return req;
  endfunction

  function automatic MemRequest makeLoad(input logic [31:0] addr, input logic [1:0] size,
                                         input logic signExt);
    MemRequest req;
    req                   = '0;
    req.addr              = addr;
    req.loadType.readMem  = 1'b1;
    req.loadType.size     = size;
    req.loadType.signExt  = signExt;
    return req;
  endfunction

  function automatic logic [1:0] randomSize();
    logic [31:0] r;
    r = $urandom % 3;
    return r[1:0];
  endfunction

  // Aligned address inside the low 4 KB
  function automatic logic [31:0] randomAddr(input logic [1:0] size);
    logic [31:0] a;
    a = $urandom & 32'h0000_0fff;
    case (size)
      ACCESS_WORD: a = a & ~32'd3;
      ACCESS_HALF: a = a & ~32'd1;
      default:     a = a;
    endcase
    return a;
  endfunction

  function automatic ExceptFlags randomFlags();
    logic [31:0] r;
    r = $urandom;
    return r[8:0];
  endfunction

  // Idle, store or load with random flags, a quarter of them unaligned
  function automatic MemRequest randomRequest();
    MemRequest   req;
    logic [31:0] r;
    logic [31:0] addr;
    logic [1:0]  size;
    r    = $urandom % 5;
    size = randomSize();
    addr = ($urandom % 4 == 0) ? ($urandom & 32'h0000_0fff) : randomAddr(size);
    case (r)
      0:       req = '0;
      1, 2:    req = makeStore(addr, $urandom, size);
      default: req = makeLoad(addr, size, r[0]);
    endcase
    req.addr   = addr;
    req.except = randomFlags();
    return req;
  endfunction

  task automatic checkOldest();
    MemResult exp;
    if (pending.size() > 0) begin
      exp = pending.pop_front();
      checkValue({31'b0, result.valid}, {31'b0, exp.valid}, "result valid");
      checkValue(result.loadData, exp.loadData, "load data");
      checkValue({23'b0, result.except}, {23'b0, exp.except}, "exception flags");
    end
  endtask

  // One request per cycle, result of the previous one checked first
  task automatic issue(input MemRequest req);
    @(posedge clk);
    #1;
    checkOldest();
    request = req;
    pending.push_back(predict(req));
  endtask

  task automatic flushPipe();
    issue('0);
    @(posedge clk);
    #1;
    checkOldest();
  endtask

  task automatic waitForValid(output int cycles);
    int n;
    cycles = 0;
    for (n = 1; n <= 8; n++) begin
      @(posedge clk);
      #1;
      if (result.valid) begin
        cycles = n;
        break;
      end
    end
    if (cycles == 0) begin
      timedOut = 1'b1;
      $display("timeout: result valid never went high after the first request");
    end
  endtask

  task automatic finishTest(input string name);
    testCount++;
    $display("%s: %0d checks, %0d errors", name, checkCount - testChecks,
             errorCount - testErrors);
    testChecks = checkCount;
    testErrors = errorCount;
  endtask

  initial begin
    logic [31:0] addr;
    logic [31:0] rnd;
    logic [1:0]  size;
    logic [1:0]  low;
    int          latency;
    MemRequest   req;
    logic [31:0] storedAddr [$];

    void'($urandom(32'h72c7_ef90));
    reset      = 1'b1;
    request    = '0;
    checkCount = 0;
    errorCount = 0;
    testCount  = 0;
    testChecks = 0;
    testErrors = 0;
    timedOut   = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    checkValue({31'b0, result.valid}, 32'b0, "valid after reset");
    flushPipe();                                   // Idle cycle gives no result
    request = makeStore(32'h0, 32'h0, ACCESS_WORD);
    void'(predict(request));
    waitForValid(latency);
    request = '0;
    if (!timedOut) begin
      checkValue(latency, 32'd1, "result latency");
    end
    finishTest("reset and idle");

    if (!timedOut) begin
      // Known contents everywhere, pattern spans the whole address
      for (int i = 0; i < RAM_WORDS; i++) begin
        addr = i * 4;
        issue(makeStore(addr, (addr * 32'h9e37_79b9) ^ 32'h3c5a_0f0f, ACCESS_WORD));
      end
      flushPipe();
      finishTest("memory fill");

      repeat (40) begin
        size = randomSize();
        addr = randomAddr(size);
        storedAddr.push_back(addr);
        issue(makeStore(addr, $urandom, size));
      end
      while (storedAddr.size() > 0) begin
        issue(makeLoad(storedAddr.pop_front() & ~32'd3, ACCESS_WORD, 1'b0));
      end
      flushPipe();
      finishTest("aligned stores");

      repeat (80) begin
        size = randomSize();
        rnd  = $urandom;
        issue(makeLoad(randomAddr(size), size, rnd[0]));
      end
      flushPipe();
      finishTest("aligned loads");

      repeat (20) begin
        rnd  = $urandom;
        low  = (rnd[1:0] == 2'b00) ? 2'b01 : rnd[1:0];
        addr = randomAddr(ACCESS_WORD) | {30'b0, low};
        issue(makeStore(addr, $urandom, ACCESS_WORD));
        issue(makeLoad(addr & ~32'd3, ACCESS_WORD, 1'b0));   // Word must be untouched
        addr = randomAddr(ACCESS_HALF) | 32'd1;
        issue(makeStore(addr, $urandom, ACCESS_HALF));
        issue(makeLoad(addr & ~32'd3, ACCESS_WORD, 1'b0));
        issue(makeLoad(addr, ACCESS_HALF, rnd[2]));
        issue(makeLoad(randomAddr(ACCESS_WORD) | {30'b0, low}, ACCESS_WORD, rnd[3]));
      end
      flushPipe();
      finishTest("misaligned accesses");

      repeat (100) begin
        issue(randomRequest());
      end
      flushPipe();
      finishTest("exception flags");

      repeat (60) begin
        size = randomSize();
        addr = randomAddr(size);
        req  = makeStore(addr, $urandom, size);
        req.except = randomFlags();
        issue(req);
        size = randomSize();
        rnd  = $urandom;
        req  = makeLoad((addr & ~32'd3) | (randomAddr(size) & 32'd3), size, rnd[0]);
        req.except = randomFlags();
        issue(req);                                // Same word right after the store
        issue(randomRequest());
      end
      flushPipe();
      finishTest("back-to-back traffic");
    end

    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0 && !timedOut) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* source/memStage.sv */
// Memory stage top level
// Store formatting, data RAM and load alignment
`timescale 1ns/1ns

module memStage import memStagePkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  MemRequest request,
  output MemResult  result
);

  logic [RAM_INDEX_BITS-1:0] wordIndex;
  logic [31:0]               writeData;
  logic [3:0]                byteEnable;
  logic [31:0]               readData;
  ExceptFlags                exceptOut;   // Flags with address errors applied

  storeFormat storeFormat (
    .request    (request),
    .wordIndex  (wordIndex),
    .writeData  (writeData),
    .byteEnable (byteEnable),
    .exceptOut  (exceptOut)
  );

  dataRam dataRam (
    .clk        (clk),
    .wordIndex  (wordIndex),
    .writeData  (writeData),
    .byteEnable (byteEnable),
    .readData   (readData)
  );

  // Result one cycle after the request edge
  loadAlign loadAlign (
    .clk        (clk),
    .reset      (reset),
    .request    (request),
    .exceptIn   (exceptOut),
    .readData   (readData),
    .result     (result)
  );

endmodule

/* source/loadAlign.sv */
// Load context register and loaded data extraction
// Picks the addressed byte or halfword and extends it to 32 bits
`timescale 1ns/1ns

module loadAlign import memStagePkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  MemRequest   request,
  input  ExceptFlags  exceptIn,
  input  logic [31:0] readData,
  output MemResult    result
);

  // What the load needs to know one cycle later
  typedef struct packed {
    logic       valid;
    LoadType    loadType;
    logic [1:0] lowAddr;
    ExceptFlags except;
  } LoadContext;

  LoadContext  ctxNext;
  LoadContext  ctx;
  logic [7:0]  loadByte;
  logic [15:0] loadHalf;
  logic [31:0] extended;
  logic        dropData;

  always_comb begin
    ctxNext.valid    = request.loadType.readMem | request.storeType.dmWr;
    ctxNext.loadType = request.loadType;
    ctxNext.lowAddr  = request.addr[1:0];
    ctxNext.except   = exceptIn;
  end

  // Lines up with the RAM read register
  always_ff @(posedge clk) begin
    if (reset) begin
      ctx <= '0;
    end else begin
      ctx <= ctxNext;
    end
  end

  assign loadByte = readData[{ctx.lowAddr, 3'b000} +: 8];
  assign loadHalf = ctx.lowAddr[1] ? readData[31:16] : readData[15:0];

  always_comb begin
    case (ctx.loadType.size)
      ACCESS_WORD: extended = readData;
      ACCESS_HALF: begin
        extended = {{16{ctx.loadType.signExt & loadHalf[15]}}, loadHalf};
      end
      ACCESS_BYTE: begin
        extended = {{24{ctx.loadType.signExt & loadByte[7]}}, loadByte};
      end
      default:     extended = 32'b0;
    endcase
  end

  // Stores and misaligned loads return no data
  assign dropData = !ctx.loadType.readMem || ctx.except.rdWrongAddressInMem;

  always_comb begin
    result.valid    = ctx.valid;
    result.loadData = dropData ? 32'b0 : extended;
    result.except   = ctx.except;
  end

endmodule

/* source/dataRam.sv */
// Byte-writable data RAM
// Registered read, returns the old word on a same-cycle write
`timescale 1ns/1ns

module dataRam import memStagePkg::*; (
  input  logic                      clk,
  input  logic [RAM_INDEX_BITS-1:0] wordIndex,
  input  logic [31:0]               writeData,
  input  logic [3:0]                byteEnable,
  output logic [31:0]               readData
);

  logic [31:0] words [0:RAM_WORDS-1];

  // Per-byte writes
  always_ff @(posedge clk) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (byteEnable[lane]) begin
        words[wordIndex][8*lane +: 8] <= writeData[8*lane +: 8];
      end
    end
  end

  // Read every edge, sees the pre-write contents
  always_ff @(posedge clk) begin
    readData <= words[wordIndex];
  end

endmodule

/* source/storeFormat.sv */
// Store lane steering and byte write enables
// Also raises the load/store address-error flags
`timescale 1ns/1ns

module storeFormat import memStagePkg::*; (
  input  MemRequest                 request,
  output logic [RAM_INDEX_BITS-1:0] wordIndex,
  output logic [31:0]               writeData,
  output logic [3:0]                byteEnable,
  output ExceptFlags                exceptOut
);

  logic [1:0]  lowAddr;
  logic        storeMisaligned;
  logic        loadMisaligned;
  logic [3:0]  laneEnable;

  // True when the access breaks natural alignment for its size
  function automatic logic misaligned(input logic [1:0] size, input logic [1:0] low);
    logic bad;
    case (size)
      ACCESS_WORD: bad = (low != 2'b00);
      ACCESS_HALF: bad = low[0];
      default:     bad = 1'b0;      // Bytes always aligned
    endcase
    return bad;
  endfunction

  assign lowAddr   = request.addr[1:0];
  assign wordIndex = request.addr[RAM_INDEX_BITS+1:2];

  assign storeMisaligned = request.storeType.dmWr &&
                           misaligned(request.storeType.size, lowAddr);
  assign loadMisaligned  = request.loadType.readMem &&
                           misaligned(request.loadType.size, lowAddr);

  // Move the store data onto its byte lanes
  always_comb begin
    writeData  = 32'b0;
    laneEnable = 4'b0000;
    if (request.storeType.dmWr) begin
      case (request.storeType.size)
        ACCESS_WORD: begin
          writeData  = request.storeData;
          laneEnable = 4'b1111;
        end
        ACCESS_HALF: begin
          // Half picked by addr[1]
          writeData  = {16'b0, request.storeData[15:0]} << {lowAddr[1], 4'b0000};
          laneEnable = 4'b0011 << {lowAddr[1], 1'b0};
        end
        ACCESS_BYTE: begin
          writeData  = {24'b0, request.storeData[7:0]} << {lowAddr, 3'b000};
          laneEnable = 4'b0001 << lowAddr;
        end
        default: begin
          writeData  = 32'b0;
          laneEnable = 4'b0000;
        end
      endcase
    end
  end

  assign byteEnable = storeMisaligned ? 4'b0000 : laneEnable;  // No write on address error

  // Only the two memory address flags change here
  always_comb begin
    exceptOut                     = request.except;
    exceptOut.wrWrongAddressInMem = storeMisaligned;
    exceptOut.rdWrongAddressInMem = loadMisaligned;
  end

endmodule

/* source/memStagePkg.sv */
// Shared memory stage definitions
// Access size codes, exception flags, request/result structs, RAM sizing
package memStagePkg;

  // Access size codes, common to loads and stores
  localparam logic [1:0] ACCESS_WORD = 2'b00;
  localparam logic [1:0] ACCESS_HALF = 2'b01;
  localparam logic [1:0] ACCESS_BYTE = 2'b10;

  // Data RAM geometry, word index comes from addr[11:2]
  localparam int RAM_WORDS      = 1024;
  localparam int RAM_INDEX_BITS = 10;

  typedef struct packed {
    logic       dmWr;       // Request is a store
    logic [1:0] size;
  } StoreType;

  typedef struct packed {
    logic       readMem;    // Request is a load
    logic [1:0] size;
    logic       signExt;    // Sign-extend the loaded value
  } LoadType;

  // Flags gathered along the pipeline
  typedef struct packed {
    logic interrupt;
    logic wrongAddressInIf;
    logic reservedInstruction;
    logic syscall;
    logic breakPoint;
    logic eret;
    logic wrWrongAddressInMem;  // Misaligned store
    logic rdWrongAddressInMem;  // Misaligned load
    logic overflow;
  } ExceptFlags;

  // One request from the execute side, 80 bits
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] storeData;
    StoreType    storeType;
    LoadType     loadType;
    ExceptFlags  except;
  } MemRequest;

  // Writeback result, 42 bits
  typedef struct packed {
    logic        valid;
    logic [31:0] loadData;
    ExceptFlags  except;
  } MemResult;

endpackage
